// File: src.f
+incdir+testbench
design/cpu_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu_top.sv
testbench/clock_gen.sv
testbench/tb_cpu.sv

// File: Makefile
# Verilator flow for the five-stage CPU

VERILATOR  ?= verilator
TOP        ?= tb_cpu
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the binary exits non-zero when the testbench stops with $fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/isa_model.svh
// isa reference model
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam int             MAX_PROG = 160;
localparam cpu_pkg::addr_t WIN_BASE = 16'h0200; // 16-word data window

typedef struct packed {
    cpu_pkg::addr_t addr;
    cpu_pkg::word_t data;
} host_wr_t;

cpu_pkg::word_t prog [MAX_PROG];
int             prog_len;
host_wr_t       exp_q [$];

// low is the immediate, or rt in the top nibble for register ops
function automatic cpu_pkg::word_t enc(cpu_pkg::opcode_t op, int rd, int rs, logic [15:0] low);
    return {op, 4'(rd), 4'(rs), low};
endfunction

function automatic void emit(input cpu_pkg::word_t ins);
    prog[prog_len] = ins;
    prog_len++;
endfunction

function automatic void build_program();
    int               fix [$];     // branch slots waiting for a target
    int               kind, rd, last_rd, top, span;
    cpu_pkg::opcode_t op;
    prog_len = 0;
    last_rd  = 1;
    for (int k = 0; k < 16; k++) begin
        rd = k % 15 + 1;
        emit(enc(cpu_pkg::ADDI, rd, 0, 16'($urandom)));
        emit(enc(cpu_pkg::SW, rd, 0, WIN_BASE + 16'(4 * k)));
    end
    for (int n = $urandom_range(40, 60); n > 0; n--) begin
        kind = $urandom_range(0, 9);
        rd   = $urandom_range(1, 15);
        case (kind)
            0, 1, 2: begin
                op = cpu_pkg::opcode_t'(8'($urandom_range(1, 5))); // add .. xor
                emit(enc(op, rd, ($urandom_range(0, 1) != 0) ? last_rd : $urandom_range(0, 15),
                         {4'($urandom_range(0, 15)), 12'h000}));
                last_rd = rd;
            end
            3: begin
                emit(enc(cpu_pkg::ADDI, rd, last_rd, 16'($urandom)));
                last_rd = rd;
            end
            4: begin
                emit(enc(cpu_pkg::LW, rd, 0, WIN_BASE + 16'(4 * $urandom_range(0, 15))));
                last_rd = rd;
            end
            5: emit(enc(cpu_pkg::SW, last_rd, 0, WIN_BASE + 16'(4 * $urandom_range(0, 15))));
            6, 7: emit(enc(cpu_pkg::SW, last_rd, 0,
                           cpu_pkg::HOST_BASE + 16'(4 * $urandom_range(0, 63))));
            8: begin
                // compare, then a conditional branch on the fresh flags
                emit(enc(cpu_pkg::SUB, rd, last_rd,
                         {($urandom_range(0, 1) != 0) ? 4'(last_rd) : 4'($urandom_range(0, 15)),
                          12'h000}));
                last_rd = rd;
                op = cpu_pkg::opcode_t'(8'(8'h31 + 2 * $urandom_range(0, 2))); // beq bne blt
                fix.push_back(prog_len);
                emit(enc(op, 0, 0, 16'h0000));
            end
            default: begin
                fix.push_back(prog_len);
                emit(enc(cpu_pkg::JMP, 0, 0, 16'h0000));
            end
        endcase
    end
    top = prog_len; // closing host store that no branch skips
    emit(enc(cpu_pkg::SW, 1, 0, cpu_pkg::HOST_BASE + 16'h00fc));
    emit(enc(cpu_pkg::JMP, 0, 0, 16'(4 * top + 4)));
    foreach (fix[i]) begin
        span = top - fix[i];
        if (span > 6)
            span = 6;
        prog[fix[i]][15:0] = 16'(4 * (fix[i] + $urandom_range(1, span)));
    end
endfunction

// runs the program one instruction at a time and queues the host writes
function automatic void run_model();
    cpu_pkg::word_t    r [16];
    cpu_pkg::word_t    dm [16];
    cpu_pkg::word_t    ins, res, sx, sum;
    cpu_pkg::reg_idx_t rd, rs, rt;
    cpu_pkg::opcode_t  op;
    cpu_pkg::addr_t    ea;
    logic [3:0]        widx;
    logic              z, n, tk;
    int                pc;
    r  = '{default: '0};
    dm = '{default: '0};
    z  = 1'b0;
    n  = 1'b0;
    pc = 0;
    exp_q.delete();
    while (pc < prog_len) begin
        ins  = prog[pc];
        op   = cpu_pkg::opcode_t'(ins[31:24]);
        rd   = ins[23:20];
        rs   = ins[19:16];
        rt   = ins[15:12];
        sx   = {{16{ins[15]}}, ins[15:0]};
        sum  = r[rs] + sx;
        ea   = sum[15:0];
        widx = 4'((ea - WIN_BASE) >> 2);
        pc++;
        case (op)
            cpu_pkg::ADD:    res = r[rs] + r[rt];
            cpu_pkg::SUB:    res = r[rs] - r[rt];
            cpu_pkg::AND_OP: res = r[rs] & r[rt];
            cpu_pkg::OR_OP:  res = r[rs] | r[rt];
            cpu_pkg::XOR_OP: res = r[rs] ^ r[rt];
            default:         res = sum;
        endcase
        tk = (op == cpu_pkg::JMP) || (op == cpu_pkg::BEQ && z) ||
             (op == cpu_pkg::BNE && !z) || (op == cpu_pkg::BLT && n && !z);
        if (op inside {cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND_OP, cpu_pkg::OR_OP,
                       cpu_pkg::XOR_OP, cpu_pkg::ADDI}) begin
            z = (res == '0);
            n = res[31];
            if (rd != 0)
                r[rd] = res;
        end else if (op == cpu_pkg::LW) begin
            if (rd != 0)
                r[rd] = dm[widx];
        end else if (op == cpu_pkg::SW) begin
            if (ea >= cpu_pkg::HOST_BASE)
                exp_q.push_back(host_wr_t'{ea, r[rd]});
            else
                dm[widx] = r[rd];
        end
        if (op == cpu_pkg::JMP && int'(ea) == 4 * (pc - 1))
            break;                          // final spin
        if (tk)
            pc = int'(ea) / 4;
    end
endfunction

`endif

// File: testbench/tb_cpu.sv
// cpu pipeline testbench
`timescale 1ns/1ps

module tb_cpu;

    localparam int          NUM_TESTS    = 8;
    localparam int          CLK_NS       = 4;
    localparam int          RST_CYCLES   = 10;
    localparam int          QUIET_CYCLES = 50;
    localparam int unsigned SEED         = 32'h46f8_2e56;

    logic           clk;
    logic           rst_n;
    logic           run;
    logic           imem_wrt_en;
    cpu_pkg::addr_t imem_wrt_addr;
    cpu_pkg::word_t imem_wrt_data;
    logic           host_wrt;
    cpu_pkg::addr_t host_addr;
    cpu_pkg::word_t host_data;

    `include "isa_model.svh"

    clock_gen clk_src (
        .clk (clk)
    );

    cpu_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .imem_wrt_en   (imem_wrt_en),
        .imem_wrt_addr (imem_wrt_addr),
        .imem_wrt_data (imem_wrt_data),
        .host_wrt      (host_wrt),
        .host_addr     (host_addr),
        .host_data     (host_data)
    );

    //////////////////////////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////////////////////////
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h",
                               name, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        run   = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // host_wrt must stay quiet while the loader runs
    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clk);
            compare("host_wrt", 32'h0, 32'(host_wrt));
            imem_wrt_en   = 1'b1;
            imem_wrt_addr = 16'(4 * i);
            imem_wrt_data = prog[i];
        end
        @(negedge clk);
        imem_wrt_en = 1'b0;
    endtask

    task automatic run_and_check();
        host_wr_t exp;
        int       quiet;
        quiet = 0;
        run   = 1'b1;
        while (quiet < QUIET_CYCLES) begin
            @(negedge clk);
            if (exp_q.size() == 0) begin
                compare("host_wrt", 32'h0, 32'(host_wrt)); // program is spinning
                quiet++;
            end else if (host_wrt) begin
                exp = exp_q.pop_front();
                compare("host_addr", 32'(exp.addr), 32'(host_addr));
                compare("host_data", exp.data, host_data);
            end
        end
        run = 1'b0;
    endtask

    initial begin
        rst_n         = 1'b0;
        run           = 1'b0;
        imem_wrt_en   = 1'b0;
        imem_wrt_addr = '0;
        imem_wrt_data = '0;
        void'($urandom(SEED));
        for (int t = 0; t < NUM_TESTS; t++) begin
            apply_reset();
            build_program();
            load_program();
            run_model();
            run_and_check();
        end
        $display("=== PASS ===");
        $finish;
    end

    // watchdog
    initial begin
        #(NUM_TESTS * MAX_PROG * 6 * CLK_NS);
        fail_run("timeout: the CPU did not finish its programs in the allowed time");
    end

endmodule

// File: testbench/clock_gen.sv
// testbench clock source
`timescale 1ns/1ps

module clock_gen (
    output logic clk
);

    localparam real HALF_PERIOD = 2.0; // 4 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// File: design/cpu_top.sv
// five-stage cpu top level
`timescale 1ns/1ps

module cpu_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           run,
    input  logic           imem_wrt_en,
    input  cpu_pkg::addr_t imem_wrt_addr,
    input  cpu_pkg::word_t imem_wrt_data,
    output logic           host_wrt,
    output cpu_pkg::addr_t host_addr,
    output cpu_pkg::word_t host_data
);

    cpu_pkg::if_id_t      if_id;
    cpu_pkg::id_ex_t      id_ex;
    cpu_pkg::ex_mem_t     ex_mem;
    cpu_pkg::mem_wb_t     mem_wb;
    cpu_pkg::fetch_ctrl_t fetch_ctrl;  // decode -> fetch
    cpu_pkg::redirect_t   redirect;    // execute -> fetch

    //////////////////////////////////////////////////////////////////////
    // pipeline
    //////////////////////////////////////////////////////////////////////
    fetch_stage u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .imem_wrt_en   (imem_wrt_en),
        .imem_wrt_addr (imem_wrt_addr),
        .imem_wrt_data (imem_wrt_data),
        .fetch_ctrl    (fetch_ctrl),
        .redirect      (redirect),
        .if_id         (if_id)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .if_id      (if_id),
        .ex_mem     (ex_mem),
        .mem_wb     (mem_wb),  // writeback lands here
        .id_ex      (id_ex),
        .fetch_ctrl (fetch_ctrl)
    );

    execute_stage u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .redirect (redirect)
    );

    memory_stage u_memory (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_mem    (ex_mem),
        .mem_wb    (mem_wb),
        .host_wrt  (host_wrt),
        .host_addr (host_addr),
        .host_data (host_data)
    );

endmodule

// File: design/memory_stage.sv
// memory access stage
`timescale 1ns/1ps

module memory_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::ex_mem_t ex_mem,
    output cpu_pkg::mem_wb_t mem_wb,
    output logic             host_wrt,
    output cpu_pkg::addr_t   host_addr,
    output cpu_pkg::word_t   host_data
);

    cpu_pkg::word_t                 dmem [cpu_pkg::DMEM_DEPTH];
    cpu_pkg::addr_t                 mem_addr;
    logic [cpu_pkg::DMEM_AW-1:0]    dmem_idx;
    logic                           host_hit;
    cpu_pkg::word_t                 load_data;

    assign mem_addr = ex_mem.alu_res[cpu_pkg::ADDR_W-1:0];
    assign dmem_idx = mem_addr[cpu_pkg::DMEM_AW+cpu_pkg::WORD_LSB-1:cpu_pkg::WORD_LSB];
    assign host_hit = ex_mem.ctrl.mem_wrt && (mem_addr >= cpu_pkg::HOST_BASE);

    //////////////////////////////////////////////////////////////////////
    // data memory
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (ex_mem.ctrl.mem_wrt && !host_hit)
            dmem[dmem_idx] <= ex_mem.st_data;
    end

    assign load_data = dmem[dmem_idx];

    //////////////////////////////////////////////////////////////////////
    // host write window
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            host_wrt <= 1'b0;
        else
            host_wrt <= host_hit; // one pulse per store
    end

    always_ff @(posedge clk) begin
        if (host_hit) begin
            host_addr <= mem_addr;
            host_data <= ex_mem.st_data;
        end
    end

    // mem/wb
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.wrt_en   <= ex_mem.ctrl.reg_wrt;
            mem_wb.wrt_data <= ex_mem.ctrl.mem_rd ? load_data : ex_mem.alu_res;
            mem_wb.rd       <= ex_mem.rd;
        end
    end

endmodule

// File: design/execute_stage.sv
// execute stage
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::id_ex_t    id_ex,
    output cpu_pkg::ex_mem_t   ex_mem,
    output cpu_pkg::redirect_t redirect
);

    cpu_pkg::word_t alu_b;
    cpu_pkg::word_t alu_res;
    logic           zero_flag;
    logic           neg_flag;
    logic           taken;

    //////////////////////////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////////////////////////
    assign alu_b = id_ex.ctrl.imm_sel ? id_ex.imm : id_ex.rt_val;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            cpu_pkg::ADD:    alu_res = id_ex.rs_val + alu_b;
            cpu_pkg::SUB:    alu_res = id_ex.rs_val - alu_b;
            cpu_pkg::AND_OP: alu_res = id_ex.rs_val & alu_b;
            cpu_pkg::OR_OP:  alu_res = id_ex.rs_val | alu_b;
            cpu_pkg::XOR_OP: alu_res = id_ex.rs_val ^ alu_b;
            default:         alu_res = id_ex.rs_val + alu_b; // addi, ld/st, branch target
        endcase
    end

    // flags only move on arithmetic and logic ops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            zero_flag <= 1'b0;
            neg_flag  <= 1'b0;
        end else if (id_ex.ctrl.flag_en) begin
            zero_flag <= (alu_res == '0);
            neg_flag  <= alu_res[cpu_pkg::DATA_W-1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // branch resolution
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        taken = 1'b0;
        if (id_ex.ctrl.branch) begin
            case (id_ex.ctrl.alu_op)
                cpu_pkg::BEQ: taken = zero_flag;
                cpu_pkg::BNE: taken = !zero_flag;
                cpu_pkg::BLT: taken = neg_flag && !zero_flag;
                cpu_pkg::JMP: taken = 1'b1;
                default:      taken = 1'b0;
            endcase
        end
    end

    assign redirect.taken  = taken;
    assign redirect.target = alu_res[cpu_pkg::ADDR_W-1:0]; // rs + imm

    //////////////////////////////////////////////////////////////////////
    // ex/mem
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.ctrl    <= id_ex.ctrl;
            ex_mem.alu_res <= alu_res;
            ex_mem.st_data <= id_ex.rt_val; // rd value for stores
            ex_mem.rd      <= id_ex.rd;
        end
    end

endmodule

// File: design/decode_stage.sv
// instruction decode stage
`timescale 1ns/1ps

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cpu_pkg::if_id_t      if_id,
    input  cpu_pkg::ex_mem_t     ex_mem,
    input  cpu_pkg::mem_wb_t     mem_wb,
    output cpu_pkg::id_ex_t      id_ex,
    output cpu_pkg::fetch_ctrl_t fetch_ctrl
);

    cpu_pkg::word_t    regs [cpu_pkg::NUM_REGS];
    cpu_pkg::opcode_t  opc;
    cpu_pkg::ctrl_t    ctrl;
    cpu_pkg::reg_idx_t rs_idx, rt_idx, rd_idx, src2_idx;
    logic              use_rs, use_src2;
    cpu_pkg::word_t    rs_val, src2_val, imm;
    logic              freeze;

    // read port with writeback bypass and a hardwired zero r0
    function automatic cpu_pkg::word_t rf_read(input cpu_pkg::reg_idx_t idx);
        if (idx == '0)
            return '0;
        else if (mem_wb.wrt_en && (mem_wb.rd == idx))
            return mem_wb.wrt_data;
        else
            return regs[idx];
    endfunction

    // true when idx is still being produced further down the pipe
    function automatic logic raw_hit(input cpu_pkg::reg_idx_t idx, input logic used);
        return used && (idx != '0) &&
               ((id_ex.ctrl.reg_wrt && (id_ex.rd == idx)) ||
                (ex_mem.ctrl.reg_wrt && (ex_mem.rd == idx)));
    endfunction

    //////////////////////////////////////////////////////////////////////
    // control decode
    //////////////////////////////////////////////////////////////////////
    assign opc    = cpu_pkg::opcode_t'(if_id.instr[cpu_pkg::OPC_MSB:cpu_pkg::OPC_LSB]);
    assign rd_idx = if_id.instr[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
    assign rs_idx = if_id.instr[cpu_pkg::RS_MSB:cpu_pkg::RS_LSB];
    assign rt_idx = if_id.instr[cpu_pkg::RT_MSB:cpu_pkg::RT_LSB];
    assign imm    = {{(cpu_pkg::DATA_W-cpu_pkg::IMM_W){if_id.instr[cpu_pkg::IMM_MSB]}},
                     if_id.instr[cpu_pkg::IMM_MSB:cpu_pkg::IMM_LSB]};

    always_comb begin
        ctrl     = '0; // unknown opcodes behave as nop
        use_rs   = 1'b0;
        use_src2 = 1'b0;
        case (opc)
            cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND_OP, cpu_pkg::OR_OP,
            cpu_pkg::XOR_OP: begin
                ctrl.alu_op  = opc;
                ctrl.reg_wrt = 1'b1;
                ctrl.flag_en = 1'b1;
                use_rs       = 1'b1;
                use_src2     = 1'b1;
            end
            cpu_pkg::ADDI: begin
                ctrl.alu_op  = opc;
                ctrl.imm_sel = 1'b1;
                ctrl.reg_wrt = 1'b1;
                ctrl.flag_en = 1'b1;
                use_rs       = 1'b1;
            end
            cpu_pkg::LW: begin
                ctrl.alu_op  = opc;
                ctrl.imm_sel = 1'b1;
                ctrl.reg_wrt = 1'b1;
                ctrl.mem_rd  = 1'b1;
                use_rs       = 1'b1;
            end
            cpu_pkg::SW: begin
                ctrl.alu_op  = opc;
                ctrl.imm_sel = 1'b1;
                ctrl.mem_wrt = 1'b1;
                use_rs       = 1'b1;
                use_src2     = 1'b1; // store data comes from rd
            end
            cpu_pkg::BEQ, cpu_pkg::BNE, cpu_pkg::BLT, cpu_pkg::JMP: begin
                ctrl.alu_op  = opc;
                ctrl.imm_sel = 1'b1;
                ctrl.branch  = 1'b1;
                use_rs       = 1'b1; // target base
            end
            default: ;
        endcase
    end

    assign src2_idx = (opc == cpu_pkg::SW) ? rd_idx : rt_idx;

    //////////////////////////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++)
                regs[i] <= '0;
        end else if (mem_wb.wrt_en && (mem_wb.rd != '0)) begin
            regs[mem_wb.rd] <= mem_wb.wrt_data;
        end
    end

    always_comb begin
        rs_val   = rf_read(rs_idx);
        src2_val = rf_read(src2_idx);
    end

    //////////////////////////////////////////////////////////////////////
    // hazards and id/ex
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        freeze = raw_hit(rs_idx, use_rs) | raw_hit(src2_idx, use_src2);
    end

    assign fetch_ctrl.freeze = freeze;
    assign fetch_ctrl.bubble = ctrl.branch | id_ex.ctrl.branch; // hold fetch till resolved

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (freeze) begin
            id_ex <= '0; // bubble while the producer drains
        end else begin
            id_ex.ctrl   <= ctrl;
            id_ex.rs_val <= rs_val;
            id_ex.rt_val <= src2_val;
            id_ex.imm    <= imm;
            id_ex.rd     <= rd_idx;
        end
    end

endmodule

// File: design/fetch_stage.sv
// instruction fetch stage
`timescale 1ns/1ps

module fetch_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 run,
    input  logic                 imem_wrt_en,
    input  cpu_pkg::addr_t       imem_wrt_addr,
    input  cpu_pkg::word_t       imem_wrt_data,
    input  cpu_pkg::fetch_ctrl_t fetch_ctrl,
    input  cpu_pkg::redirect_t   redirect,
    output cpu_pkg::if_id_t      if_id
);

    cpu_pkg::word_t imem [cpu_pkg::IMEM_DEPTH];
    cpu_pkg::addr_t pc;
    cpu_pkg::word_t instr;

    //////////////////////////////////////////////////////////////////////
    // instruction memory
    //////////////////////////////////////////////////////////////////////

    // host loader port, written while run is low
    always_ff @(posedge clk) begin
        if (imem_wrt_en) begin
            imem[imem_wrt_addr[cpu_pkg::IMEM_AW+cpu_pkg::WORD_LSB-1:cpu_pkg::WORD_LSB]]
                <= imem_wrt_data;
        end
    end

    assign instr = imem[pc[cpu_pkg::IMEM_AW+cpu_pkg::WORD_LSB-1:cpu_pkg::WORD_LSB]];

    //////////////////////////////////////////////////////////////////////
    // pc and if/id
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            if_id.instr <= cpu_pkg::NOP_INSTR;
        end else if (!run) begin
            pc          <= '0;                 // park at reset vector
            if_id.instr <= cpu_pkg::NOP_INSTR;
        end else if (redirect.taken) begin
            pc          <= redirect.target;
            if_id.instr <= cpu_pkg::NOP_INSTR; // squash the wrong-path slot
        end else if (fetch_ctrl.freeze) begin
            pc          <= pc;
            if_id       <= if_id;              // decode retries after the hazard
        end else if (fetch_ctrl.bubble) begin
            pc          <= pc;
            if_id.instr <= cpu_pkg::NOP_INSTR; // branch in flight
        end else begin
            pc          <= pc + cpu_pkg::PC_STEP;
            if_id.instr <= instr;
        end
    end

endmodule

// File: design/cpu_pkg.sv
// cpu shared definitions
package cpu_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and basic types
    //////////////////////////////////////////////////////////////////////
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 16;
    localparam int REG_IDX_W = 4;
    localparam int NUM_REGS  = 16;
    localparam int WORD_LSB  = $clog2(DATA_W / 8); // byte offset bits

    typedef logic [DATA_W-1:0]    word_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    //////////////////////////////////////////////////////////////////////
    // instruction layout
    //////////////////////////////////////////////////////////////////////
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 24;
    localparam int RD_MSB  = 23;
    localparam int RD_LSB  = 20;
    localparam int RS_MSB  = 19;
    localparam int RS_LSB  = 16;
    localparam int RT_MSB  = 15;
    localparam int RT_LSB  = 12;
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;
    localparam int IMM_W   = IMM_MSB - IMM_LSB + 1; // sign-extended to DATA_W

    typedef enum logic [OPC_MSB-OPC_LSB:0] {
        NOP    = 8'h00,
        ADD    = 8'h01,
        SUB    = 8'h02,
        AND_OP = 8'h03,
        OR_OP  = 8'h04,
        XOR_OP = 8'h05,
        ADDI   = 8'h11,
        LW     = 8'h81,
        SW     = 8'h83,
        BEQ    = 8'h31, // branches share the 8'h3x group
        BNE    = 8'h33,
        BLT    = 8'h35,
        JMP    = 8'h3d
    } opcode_t;

    localparam word_t NOP_INSTR = {NOP, {OPC_LSB{1'b0}}};

    //////////////////////////////////////////////////////////////////////
    // memories
    //////////////////////////////////////////////////////////////////////
    localparam int    IMEM_DEPTH = 256;
    localparam int    DMEM_DEPTH = 256;
    localparam int    IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int    DMEM_AW    = $clog2(DMEM_DEPTH);
    localparam addr_t HOST_BASE  = 16'h9000; // stores here go off chip
    localparam addr_t PC_STEP    = 16'd4;

    //////////////////////////////////////////////////////////////////////
    // stage structs
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        opcode_t alu_op;
        logic    imm_sel;  // b operand from immediate
        logic    reg_wrt;
        logic    mem_wrt;
        logic    mem_rd;
        logic    branch;   // branch or jump
        logic    flag_en;  // update zero/negative
    } ctrl_t;

    typedef struct packed {
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;
        reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_res;
        word_t    st_data;
        reg_idx_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic     wrt_en;
        word_t    wrt_data;
        reg_idx_t rd;
    } mem_wb_t;

    typedef struct packed {
        logic freeze; // hold pc and if/id
        logic bubble; // hold pc, nop into if/id
    } fetch_ctrl_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } redirect_t;

endpackage
